// ==== design/forth_cfg_pkg.sv ====
package forth_cfg_pkg;

    // Data path
    localparam int word_width = 16;
    typedef logic [word_width-1:0] word_t;

    // Program memory, byte addressed
    localparam int rom_addr_width = 8;
    typedef logic [rom_addr_width-1:0] rom_addr_t;
    typedef logic [7:0] byte_t;

    // Entries per stack
    localparam int data_stack_depth = 64;
    localparam int call_stack_depth = 32;

    // Only the low rom_addr_width bits reach the program memory
    typedef logic [15:0] pc_t;

endpackage

// ==== design/forth_isa_pkg.sv ====
package forth_isa_pkg;

    // Opcodes kept from the original numbering
    localparam forth_cfg_pkg::byte_t op_push = 8'h00;
    localparam forth_cfg_pkg::byte_t op_dup  = 8'h01;
    localparam forth_cfg_pkg::byte_t op_set  = 8'h02;
    localparam forth_cfg_pkg::byte_t op_jmp  = 8'h03;
    localparam forth_cfg_pkg::byte_t op_get  = 8'h04;
    localparam forth_cfg_pkg::byte_t op_call = 8'h05;
    localparam forth_cfg_pkg::byte_t op_ret  = 8'h06;
    localparam forth_cfg_pkg::byte_t op_hlt  = 8'h08;
    localparam forth_cfg_pkg::byte_t op_br   = 8'h0A;
    localparam forth_cfg_pkg::byte_t op_br0  = 8'h0B;
    localparam forth_cfg_pkg::byte_t op_drop = 8'h0D;
    localparam forth_cfg_pkg::byte_t op_swap = 8'h0E;
    localparam forth_cfg_pkg::byte_t op_over = 8'h10;

    localparam logic [3:0] alu_group = 4'hF;   // Upper nibble of ALU opcodes

    typedef enum logic [3:0] {
        alu_add = 4'd0, alu_sub, alu_and, alu_or, alu_xor,
        alu_eq, alu_ne, alu_gt, alu_ge, alu_le, alu_lt,
        alu_shl, alu_shr
    } alu_op_t;

    typedef enum logic [1:0] {cond_always, cond_nonzero, cond_zero} br_cond_t;

    typedef enum logic [2:0] {
        stk_none, stk_push_imm, stk_dup, stk_over, stk_drop, stk_swap
    } stack_op_t;

    typedef struct packed {
        logic      has_imm;     // Two immediate bytes follow the opcode
        logic      is_branch;
        br_cond_t  br_cond;
        logic      is_call;
        logic      is_ret;
        logic      is_alu;
        stack_op_t stack_op;
        logic      mem_read;
        logic      mem_write;
        logic      halt;
        logic      illegal;
        alu_op_t   alu_op;
    } decoded_t;

endpackage

// ==== design/stack_if.sv ====
`timescale 1ns/10ps

interface stack_if #(
    parameter type payload_t = forth_cfg_pkg::word_t
) ();

    // Requests from the execute unit, one operation per cycle
    logic     push;
    logic     pop;
    logic     replace;
    payload_t wr_data;

    // State presented by the stack
    payload_t top;
    payload_t next;
    logic     empty;

    modport user (
        output push, pop, replace, wr_data,
        input  top, next, empty
    );

    modport owner (
        input  push, pop, replace, wr_data,
        output top, next, empty
    );

endinterface

// ==== design/forth_program_rom.sv ====
`timescale 1ns/10ps

module forth_program_rom (
    input  logic                      clk,
    input  logic                      load_en,
    input  forth_cfg_pkg::rom_addr_t  load_addr,
    input  forth_cfg_pkg::byte_t      load_data,
    input  forth_cfg_pkg::pc_t        pc,
    output forth_cfg_pkg::byte_t      op_byte,
    output forth_cfg_pkg::byte_t      imm_lo,
    output forth_cfg_pkg::byte_t      imm_hi
);

    forth_cfg_pkg::byte_t mem [2**forth_cfg_pkg::rom_addr_width];

    forth_cfg_pkg::rom_addr_t op_addr;
    forth_cfg_pkg::rom_addr_t lo_addr;
    forth_cfg_pkg::rom_addr_t hi_addr;

    assign op_addr = pc[forth_cfg_pkg::rom_addr_width-1:0];
    assign lo_addr = op_addr + forth_cfg_pkg::rom_addr_t'(1);
    assign hi_addr = op_addr + forth_cfg_pkg::rom_addr_t'(2);

    always_ff @(posedge clk) begin
        if (load_en)
            mem[load_addr] <= load_data;
    end

    // Immediate is stored low byte first, addresses wrap at the top
    assign op_byte = mem[op_addr];
    assign imm_lo  = mem[lo_addr];
    assign imm_hi  = mem[hi_addr];

endmodule

// ==== design/forth_decode.sv ====
`timescale 1ns/10ps

module forth_decode (
    input  forth_cfg_pkg::byte_t     op_byte,
    output forth_isa_pkg::decoded_t  decoded
);

    always_comb begin
        decoded = '0;
        decoded.alu_op = forth_isa_pkg::alu_op_t'(op_byte[3:0]);
        if (op_byte[7:4] == forth_isa_pkg::alu_group) begin
            // 0xFD to 0xFF have no operation
            decoded.is_alu  = (op_byte[3:0] <= 4'd12);
            decoded.illegal = (op_byte[3:0] > 4'd12);
        end else begin
            case (op_byte)
                forth_isa_pkg::op_push: begin
                    decoded.has_imm  = 1'b1;
                    decoded.stack_op = forth_isa_pkg::stk_push_imm;
                end
                forth_isa_pkg::op_dup:  decoded.stack_op = forth_isa_pkg::stk_dup;
                forth_isa_pkg::op_over: decoded.stack_op = forth_isa_pkg::stk_over;
                forth_isa_pkg::op_drop: decoded.stack_op = forth_isa_pkg::stk_drop;
                forth_isa_pkg::op_swap: decoded.stack_op = forth_isa_pkg::stk_swap;
                forth_isa_pkg::op_set:  decoded.mem_write = 1'b1;
                forth_isa_pkg::op_get:  decoded.mem_read = 1'b1;
                forth_isa_pkg::op_jmp, forth_isa_pkg::op_call: begin
                    decoded.has_imm   = 1'b1;
                    decoded.is_branch = 1'b1;
                    decoded.is_call   = (op_byte == forth_isa_pkg::op_call);
                end
                forth_isa_pkg::op_br, forth_isa_pkg::op_br0: begin
                    decoded.has_imm   = 1'b1;
                    decoded.is_branch = 1'b1;
                    decoded.br_cond   = (op_byte == forth_isa_pkg::op_br) ?
                                        forth_isa_pkg::cond_nonzero :
                                        forth_isa_pkg::cond_zero;
                end
                forth_isa_pkg::op_ret:  decoded.is_ret = 1'b1;
                forth_isa_pkg::op_hlt:  decoded.halt = 1'b1;
                default:                decoded.illegal = 1'b1;
            endcase
        end
    end

endmodule

// ==== design/forth_stack.sv ====
`timescale 1ns/10ps

module forth_stack #(
    parameter type payload_t = forth_cfg_pkg::word_t,
    parameter int  depth     = forth_cfg_pkg::data_stack_depth
) (
    input  logic    clk,
    input  logic    nreset,
    stack_if.owner  port
);

    localparam int aw = $clog2(depth);

    payload_t mem [depth];

    logic [aw:0]   sp;         // Extra bit tells a full stack from an empty one
    logic [aw:0]   sp_next;
    logic [aw-1:0] wr_addr;
    logic [aw-1:0] next_addr;

    // Stack grows downward, sp points at the top entry
    always_comb begin
        sp_next = sp;
        if (port.push)
            sp_next = sp - {{aw{1'b0}}, 1'b1};
        else if (port.pop)
            sp_next = sp + {{aw{1'b0}}, 1'b1};
    end

    // Push, replace and pop with replace all write the new top
    assign wr_addr   = sp_next[aw-1:0];
    assign next_addr = sp[aw-1:0] + {{(aw-1){1'b0}}, 1'b1};

    always_ff @(posedge clk) begin
        if (port.push || port.replace)
            mem[wr_addr] <= port.wr_data;
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            sp <= '0;
        end else begin
            sp <= sp_next;
        end
    end

    assign port.top   = mem[sp[aw-1:0]];
    assign port.next  = mem[next_addr];
    assign port.empty = (sp == '0);

endmodule

// ==== design/forth_execute.sv ====
`timescale 1ns/10ps

module forth_execute (
    input  logic                     clk,
    input  logic                     nreset,
    input  forth_isa_pkg::decoded_t  decoded,
    input  forth_cfg_pkg::byte_t     imm_lo,
    input  forth_cfg_pkg::byte_t     imm_hi,
    output forth_cfg_pkg::pc_t       pc,
    stack_if.user                    dstack,
    stack_if.user                    cstack,
    output logic                     mem_valid,
    output logic                     mem_write,
    output forth_cfg_pkg::word_t     mem_address,
    output forth_cfg_pkg::word_t     mem_wdata,
    input  forth_cfg_pkg::word_t     mem_rdata,
    input  logic                     mem_ready,
    output logic                     hlt,
    output logic                     error
);

    typedef enum logic [2:0] {st_fetch, st_execute, st_imm, st_swap2, st_mem_wait} state_t;

    state_t                   state;
    forth_isa_pkg::decoded_t  dec_q;
    forth_cfg_pkg::word_t     imm_q;
    forth_cfg_pkg::word_t     swap_tmp;
    forth_cfg_pkg::word_t     opa;
    forth_cfg_pkg::word_t     opb;
    forth_cfg_pkg::word_t     alu_result;
    logic                     taken;
    logic                     uses_top;
    logic                     fault;

    // ======================================================================
    // ALU and branch condition

    assign opa = dstack.next;
    assign opb = dstack.top;

    always_comb begin
        case (dec_q.alu_op)
            forth_isa_pkg::alu_add: alu_result = opa + opb;
            forth_isa_pkg::alu_sub: alu_result = opa - opb;
            forth_isa_pkg::alu_and: alu_result = opa & opb;
            forth_isa_pkg::alu_or:  alu_result = opa | opb;
            forth_isa_pkg::alu_xor: alu_result = opa ^ opb;
            forth_isa_pkg::alu_eq:  alu_result = forth_cfg_pkg::word_t'(opa == opb);
            forth_isa_pkg::alu_ne:  alu_result = forth_cfg_pkg::word_t'(opa != opb);
            forth_isa_pkg::alu_gt:  alu_result = forth_cfg_pkg::word_t'(opa > opb);
            forth_isa_pkg::alu_ge:  alu_result = forth_cfg_pkg::word_t'(opa >= opb);
            forth_isa_pkg::alu_le:  alu_result = forth_cfg_pkg::word_t'(opa <= opb);
            forth_isa_pkg::alu_lt:  alu_result = forth_cfg_pkg::word_t'(opa < opb);
            forth_isa_pkg::alu_shl: alu_result = opa << opb;
            forth_isa_pkg::alu_shr: alu_result = opa >> opb;
            default:                alu_result = '0;
        endcase
    end

    always_comb begin
        case (dec_q.br_cond)
            forth_isa_pkg::cond_nonzero: taken = (dstack.top != '0);
            forth_isa_pkg::cond_zero:    taken = (dstack.top == '0);
            default:                     taken = 1'b1;
        endcase
    end

    // Underflow on either stack is treated like an illegal opcode
    assign uses_top = dec_q.is_alu | dec_q.mem_read | dec_q.mem_write
                    | (dec_q.is_branch & (dec_q.br_cond != forth_isa_pkg::cond_always))
                    | ((dec_q.stack_op != forth_isa_pkg::stk_none)
                       & (dec_q.stack_op != forth_isa_pkg::stk_push_imm));
    assign fault = dec_q.illegal | (uses_top & dstack.empty) | (dec_q.is_ret & cstack.empty);

    // ======================================================================
    // Stack requests

    always_comb begin
        dstack.push    = 1'b0;
        dstack.pop     = 1'b0;
        dstack.replace = 1'b0;
        dstack.wr_data = alu_result;
        cstack.push    = 1'b0;
        cstack.pop     = 1'b0;
        cstack.replace = 1'b0;
        cstack.wr_data = pc + forth_cfg_pkg::pc_t'(3);   // Return past the immediate
        case (state)
            st_execute: begin
                if (!fault && !dec_q.halt) begin
                    case (dec_q.stack_op)
                        forth_isa_pkg::stk_dup: begin
                            dstack.push    = 1'b1;
                            dstack.wr_data = dstack.top;
                        end
                        forth_isa_pkg::stk_over: begin
                            dstack.push    = 1'b1;
                            dstack.wr_data = dstack.next;
                        end
                        forth_isa_pkg::stk_drop: dstack.pop = 1'b1;
                        forth_isa_pkg::stk_swap: begin
                            dstack.pop     = 1'b1;   // Old top lands one down
                            dstack.replace = 1'b1;
                            dstack.wr_data = dstack.top;
                        end
                        default: begin
                            dstack.pop     = dec_q.is_alu | dec_q.mem_write
                                           | (dec_q.is_branch
                                              & (dec_q.br_cond != forth_isa_pkg::cond_always));
                            dstack.replace = dec_q.is_alu;
                        end
                    endcase
                    cstack.push = dec_q.is_call;
                    cstack.pop  = dec_q.is_ret;
                end
            end
            st_imm: begin
                dstack.push    = (dec_q.stack_op == forth_isa_pkg::stk_push_imm);
                dstack.wr_data = imm_q;
            end
            st_swap2: begin
                dstack.push    = 1'b1;
                dstack.wr_data = swap_tmp;
            end
            st_mem_wait: begin
                if (mem_ready) begin
                    dstack.pop     = dec_q.mem_write;   // Second pop of set
                    dstack.replace = dec_q.mem_read;
                    dstack.wr_data = mem_rdata;
                end
            end
            default: ;
        endcase
    end

    // ======================================================================
    // Sequencer

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state     <= st_fetch;
            dec_q     <= '0;
            pc        <= '0;
            mem_valid <= 1'b0;
            mem_write <= 1'b0;
            hlt       <= 1'b0;
            error     <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (!hlt && !error) begin
                        dec_q <= decoded;
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    state <= st_fetch;
                    if (fault) begin
                        error <= 1'b1;
                    end else if (dec_q.halt) begin
                        hlt <= 1'b1;
                    end else if (dec_q.has_imm) begin
                        if (taken)
                            state <= st_imm;
                        else
                            pc <= pc + forth_cfg_pkg::pc_t'(3);
                    end else if (dec_q.is_ret) begin
                        pc <= cstack.top;
                    end else if (dec_q.stack_op == forth_isa_pkg::stk_swap) begin
                        state <= st_swap2;
                    end else if (dec_q.mem_read || dec_q.mem_write) begin
                        mem_valid <= 1'b1;
                        mem_write <= dec_q.mem_write;
                        state     <= st_mem_wait;
                    end else begin
                        pc <= pc + forth_cfg_pkg::pc_t'(1);
                    end
                end
                st_imm: begin
                    state <= st_fetch;
                    pc    <= dec_q.is_branch ? imm_q : pc + forth_cfg_pkg::pc_t'(3);
                end
                st_swap2: begin
                    state <= st_fetch;
                    pc    <= pc + forth_cfg_pkg::pc_t'(1);
                end
                st_mem_wait: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        mem_write <= 1'b0;
                        pc        <= pc + forth_cfg_pkg::pc_t'(1);
                        state     <= st_fetch;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

    // Operands held for the later cycles of an instruction
    always_ff @(posedge clk) begin
        if (state == st_fetch)
            imm_q <= {imm_hi, imm_lo};
        if (state == st_execute) begin
            swap_tmp    <= dstack.next;
            mem_address <= dstack.top;
            mem_wdata   <= dstack.next;
        end
    end

endmodule

// ==== design/forth_cpu.sv ====
`timescale 1ns/10ps

module forth_cpu (
    input  logic                      clk,
    input  logic                      nreset,
    input  logic                      load_en,
    input  forth_cfg_pkg::rom_addr_t  load_addr,
    input  forth_cfg_pkg::byte_t      load_data,
    output logic                      mem_valid,
    output logic                      mem_write,
    output forth_cfg_pkg::word_t      mem_address,
    output forth_cfg_pkg::word_t      mem_wdata,
    input  forth_cfg_pkg::word_t      mem_rdata,
    input  logic                      mem_ready,
    output logic                      hlt,
    output logic                      error
);

    forth_cfg_pkg::pc_t       pc;
    forth_cfg_pkg::byte_t     op_byte;
    forth_cfg_pkg::byte_t     imm_lo;
    forth_cfg_pkg::byte_t     imm_hi;
    forth_isa_pkg::decoded_t  decoded;

    stack_if #(.payload_t(forth_cfg_pkg::word_t)) dstack_if ();
    stack_if #(.payload_t(forth_cfg_pkg::pc_t))   cstack_if ();

    forth_program_rom forth_program_rom_inst (
        .clk, .load_en, .load_addr, .load_data,
        .pc, .op_byte, .imm_lo, .imm_hi
    );

    forth_decode forth_decode_inst (.op_byte, .decoded);

    forth_stack #(
        .payload_t(forth_cfg_pkg::word_t),
        .depth(forth_cfg_pkg::data_stack_depth)
    ) data_stack_inst (.clk, .nreset, .port(dstack_if.owner));

    forth_stack #(
        .payload_t(forth_cfg_pkg::pc_t),
        .depth(forth_cfg_pkg::call_stack_depth)
    ) call_stack_inst (.clk, .nreset, .port(cstack_if.owner));

    forth_execute forth_execute_inst (
        .clk, .nreset, .decoded, .imm_lo, .imm_hi, .pc,
        .dstack(dstack_if.user),
        .cstack(cstack_if.user),
        .mem_valid, .mem_write, .mem_address, .mem_wdata,
        .mem_rdata, .mem_ready, .hlt, .error
    );

endmodule

// ==== dv/tb_forth_tests.svh ====
    // ======================================================================
    // Checking and reference values

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_end_state(input logic exp_hlt, input string name);
        check_value(word_t'(hlt), word_t'(exp_hlt), {name, " hlt"});
        check_value(word_t'(error), word_t'(!exp_hlt), {name, " error"});
    endtask

    function automatic word_t fill_word(input int addr);
        return {addr[7:0] ^ 8'hA5, ~addr[7:0]};
    endfunction

    // Result of next op top, comparisons unsigned
    function automatic word_t alu_expect(input int op, input word_t a, input word_t b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return (a == b) ? 16'd1 : 16'd0;
            6:       return (a != b) ? 16'd1 : 16'd0;
            7:       return (a > b)  ? 16'd1 : 16'd0;
            8:       return (a >= b) ? 16'd1 : 16'd0;
            9:       return (a <= b) ? 16'd1 : 16'd0;
            10:      return (a < b)  ? 16'd1 : 16'd0;
            11:      return a << b;
            default: return a >> b;
        endcase
    endfunction

    task automatic draw_delays();
        int i;
        for (i = 0; i < 64; i++)
            ready_delays[i] = $random(seed) & 3;
    endtask

    // ======================================================================
    // Program building

    task automatic emit_op(input byte_t op);
        prog.push_back(op);
        instr_total++;
    endtask

    task automatic emit_imm(input byte_t op, input word_t value);
        emit_op(op);
        prog.push_back(value[7:0]);     // Low byte first
        prog.push_back(value[15:8]);
    endtask

    task automatic emit_alu(input int op);
        emit_op({forth_isa_pkg::alu_group, 4'(op)});
    endtask

    task automatic emit_store(input word_t value, input word_t addr);
        emit_imm(forth_isa_pkg::op_push, value);
        emit_imm(forth_isa_pkg::op_push, addr);
        emit_op(forth_isa_pkg::op_set);
    endtask

    // Target filled in later by resolve_forward
    task automatic emit_forward(input byte_t op, output int slot);
        emit_imm(op, 16'h0000);
        slot = prog.size() - 2;
    endtask

    task automatic resolve_forward(input int slot);
        word_t target;
        target = word_t'(prog.size());
        prog[slot]     = target[7:0];
        prog[slot + 1] = target[15:8];
    endtask

    // Loads the program while in reset, then runs until hlt or error
    task automatic load_and_run();
        int i;
        @(posedge clk);
        nreset <= 1'b0;
        for (i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= forth_cfg_pkg::rom_addr_t'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (2) @(posedge clk);
        nreset <= 1'b1;
        @(posedge clk);
        while (!hlt && !error)
            @(posedge clk);
        check_value(word_t'(stray_writes), 16'd0, "writes outside data memory");
        prog.delete();
    endtask

    // ======================================================================
    // Directed tests

    task automatic test_alu();
        word_t a [13];
        word_t b [13];
        int    i;
        for (i = 0; i < 13; i++) begin
            a[i] = word_t'($random(seed));
            b[i] = word_t'($random(seed));
            if (i == 5)
                b[i] = a[i];            // Equal operands for eq
            if (i >= 11)
                b[i] = b[i] & 16'h000F;
            emit_imm(forth_isa_pkg::op_push, a[i]);
            emit_imm(forth_isa_pkg::op_push, b[i]);
            emit_alu(i);
            emit_imm(forth_isa_pkg::op_push, word_t'(16'h10 + i));
            emit_op(forth_isa_pkg::op_set);
        end
        emit_op(forth_isa_pkg::op_hlt);
        load_and_run();
        check_end_state(1'b1, "alu");
        for (i = 0; i < 13; i++)
            check_value(data_mem[16 + i], alu_expect(i, a[i], b[i]),
                        $sformatf("alu op %0d on %h, %h", i, a[i], b[i]));
        check_value(word_t'(write_count), 16'd13, "alu write count");
    endtask

    task automatic test_stack_shuffle();
        emit_imm(forth_isa_pkg::op_push, 16'h1234);     // A
        emit_imm(forth_isa_pkg::op_push, 16'hBEEF);     // A B
        emit_op(forth_isa_pkg::op_over);                // A B A
        emit_op(forth_isa_pkg::op_dup);                 // A B A A
        emit_imm(forth_isa_pkg::op_push, 16'h0F0F);     // A B A A C
        emit_op(forth_isa_pkg::op_swap);                // A B A C A
        emit_op(forth_isa_pkg::op_drop);                // A B A C
        emit_imm(forth_isa_pkg::op_push, 16'h0020);
        emit_op(forth_isa_pkg::op_set);
        emit_imm(forth_isa_pkg::op_push, 16'h0021);
        emit_op(forth_isa_pkg::op_set);
        emit_imm(forth_isa_pkg::op_push, 16'h0022);
        emit_op(forth_isa_pkg::op_set);
        emit_imm(forth_isa_pkg::op_push, 16'h0023);
        emit_op(forth_isa_pkg::op_set);
        emit_op(forth_isa_pkg::op_hlt);
        load_and_run();
        check_end_state(1'b1, "stack");
        check_value(data_mem[8'h20], 16'h0F0F, "stack word at 0x20");
        check_value(data_mem[8'h21], 16'h1234, "stack word at 0x21");
        check_value(data_mem[8'h22], 16'hBEEF, "stack word at 0x22");
        check_value(data_mem[8'h23], 16'h1234, "stack word at 0x23");
        check_value(word_t'(write_count), 16'd4, "stack write count");
    endtask

    task automatic test_control_flow();
        int   slot;
        int   i;
        logic expect_wr;
        emit_forward(forth_isa_pkg::op_jmp, slot);
        emit_store(16'hC030, 16'h0030);
        resolve_forward(slot);
        emit_imm(forth_isa_pkg::op_push, 16'h0001);
        emit_forward(forth_isa_pkg::op_br, slot);       // Taken
        emit_store(16'hC031, 16'h0031);
        resolve_forward(slot);
        emit_imm(forth_isa_pkg::op_push, 16'h0000);
        emit_forward(forth_isa_pkg::op_br, slot);
        emit_store(16'hC032, 16'h0032);
        resolve_forward(slot);
        emit_imm(forth_isa_pkg::op_push, 16'h0000);
        emit_forward(forth_isa_pkg::op_br0, slot);      // Taken
        emit_store(16'hC033, 16'h0033);
        resolve_forward(slot);
        emit_imm(forth_isa_pkg::op_push, 16'h0005);
        emit_forward(forth_isa_pkg::op_br0, slot);
        emit_store(16'hC034, 16'h0034);
        resolve_forward(slot);
        emit_forward(forth_isa_pkg::op_call, slot);
        emit_store(16'hC036, 16'h0036);                 // Runs after the return
        emit_op(forth_isa_pkg::op_hlt);
        resolve_forward(slot);
        emit_store(16'hC035, 16'h0035);                 // Subroutine
        emit_op(forth_isa_pkg::op_ret);
        load_and_run();
        check_end_state(1'b1, "control");
        for (i = 0; i < 7; i++) begin
            expect_wr = (i == 2) || (i >= 4);
            check_value(word_t'(written[48 + i]), word_t'(expect_wr),
                        $sformatf("marker 0x%h written", 8'h30 + i));
            if (expect_wr)
                check_value(data_mem[48 + i], word_t'(16'hC030 + i),
                            $sformatf("marker 0x%h value", 8'h30 + i));
        end
        check_value(word_t'(write_count), 16'd4, "control write count");
    endtask

    task automatic test_mem_backpressure();
        int i;
        for (i = 0; i < 6; i++) begin
            emit_imm(forth_isa_pkg::op_push, word_t'(16'h40 + i));
            emit_op(forth_isa_pkg::op_get);
            emit_imm(forth_isa_pkg::op_push, 16'h0111);
            emit_alu(0);
            emit_imm(forth_isa_pkg::op_push, word_t'(16'h50 + i));
            emit_op(forth_isa_pkg::op_set);
        end
        emit_op(forth_isa_pkg::op_hlt);
        load_and_run();
        check_end_state(1'b1, "get");
        for (i = 0; i < 6; i++)
            check_value(data_mem[16'h50 + i], fill_word(16'h40 + i) + 16'h0111,
                        $sformatf("get and add from 0x%h", 8'h40 + i));
        check_value(word_t'(write_count), 16'd6, "get write count");
    endtask

    task automatic test_halt();
        emit_store(16'hD060, 16'h0060);
        emit_op(forth_isa_pkg::op_hlt);
        emit_store(16'hD061, 16'h0061);
        load_and_run();
        repeat (20) @(posedge clk);
        check_end_state(1'b1, "after hlt");
        check_value(data_mem[8'h60], 16'hD060, "store before hlt");
        check_value(word_t'(written[8'h61]), 16'd0, "store after hlt written");
        check_value(word_t'(write_count), 16'd1, "hlt write count");
    endtask

    task automatic test_illegal(input byte_t bad_op);
        emit_store(16'hE062, 16'h0062);
        emit_op(bad_op);
        emit_store(16'hE063, 16'h0063);
        emit_op(forth_isa_pkg::op_hlt);
        load_and_run();
        repeat (20) @(posedge clk);
        check_end_state(1'b0, $sformatf("opcode %h", bad_op));
        check_value(data_mem[8'h62], 16'hE062, "store before illegal opcode");
        check_value(word_t'(written[8'h63]), 16'd0, "store after illegal opcode written");
        check_value(word_t'(write_count), 16'd1, "illegal opcode write count");
    endtask

// ==== dv/tb_forth_cpu.sv ====
`timescale 1ns/10ps

module tb_forth_cpu;

    typedef forth_cfg_pkg::word_t word_t;
    typedef forth_cfg_pkg::byte_t byte_t;

    logic                      clk = 1'b0;
    logic                      nreset;
    logic                      load_en;
    forth_cfg_pkg::rom_addr_t  load_addr;
    byte_t                     load_data;
    logic                      mem_valid;
    logic                      mem_write;
    word_t                     mem_address;
    word_t                     mem_wdata;
    word_t                     mem_rdata = '0;
    logic                      mem_ready = 1'b0;
    logic                      hlt;
    logic                      error;

    // Data memory model state
    word_t  data_mem [256];
    logic   written  [256];
    int     write_count;
    int     stray_writes;           // Writes above the 256 modelled words
    int     ready_delays [64];      // Drawn once at time zero
    int     delay_idx = 0;
    int     ready_delay;
    logic   delay_armed;

    integer seed = 32'ha3ca83a3;
    int     error_count = 0;
    int     check_count = 0;
    int     cycle_count = 0;
    int     instr_total = 0;
    byte_t  prog [$];

    always #5 clk = ~clk;

    forth_cpu forth_cpu_inst (
        .clk, .nreset, .load_en, .load_addr, .load_data,
        .mem_valid, .mem_write, .mem_address, .mem_wdata,
        .mem_rdata, .mem_ready, .hlt, .error
    );

    `include "tb_forth_tests.svh"

    // ======================================================================
    // Data memory with random ready delay

    always @(posedge clk) begin : mem_model
        int k;
        if (!nreset) begin
            for (k = 0; k < 256; k++) begin
                data_mem[k] = fill_word(k);
                written[k]  = 1'b0;
            end
            write_count  = 0;
            stray_writes = 0;
            delay_armed  = 1'b0;
            mem_ready   <= 1'b0;
        end else if (mem_valid && mem_ready) begin
            mem_ready <= 1'b0;                  // Transfer completes on this edge
            if (mem_write) begin
                write_count++;
                if (mem_address > 16'd255) begin
                    stray_writes++;
                end else begin
                    data_mem[mem_address[7:0]] = mem_wdata;
                    written[mem_address[7:0]]  = 1'b1;
                end
            end
        end else if (mem_valid) begin
            if (!delay_armed) begin
                ready_delay = ready_delays[delay_idx];
                delay_idx   = (delay_idx + 1) % 64;
                delay_armed = 1'b1;
            end
            if (ready_delay == 0) begin
                mem_ready  <= 1'b1;
                mem_rdata  <= data_mem[mem_address[7:0]];
                delay_armed = 1'b0;
            end else begin
                ready_delay--;
            end
        end
    end

    // ======================================================================
    // Handshake rules of the data memory bus

    always @(posedge clk) begin : bus_checks
        logic  was_waiting;
        logic  was_done;
        word_t held_address;
        word_t held_wdata;
        logic  held_write;
        if (nreset) begin
            if (was_waiting) begin
                check_value(word_t'(mem_valid), 16'd1, "mem_valid before mem_ready");
                check_value(mem_address, held_address, "mem_address while waiting");
                check_value(mem_wdata, held_wdata, "mem_wdata while waiting");
                check_value(word_t'(mem_write), word_t'(held_write), "mem_write while waiting");
            end
            if (was_done)
                check_value(word_t'(mem_valid), 16'd0, "mem_valid after the transfer");
            if (hlt || error)
                check_value(word_t'(mem_valid), 16'd0, "mem_valid after hlt or error");
        end
        was_waiting  = nreset && mem_valid && !mem_ready;
        was_done     = nreset && mem_valid && mem_ready;
        held_address = mem_address;
        held_wdata   = mem_wdata;
        held_write   = mem_write;
    end

    // Twice 8 cycles for every instruction loaded so far
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > instr_total * 8 * 2 + 64) begin
            $display("timeout: the program did not stop after %0d cycles", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        nreset    = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        draw_delays();
        test_alu();
        test_stack_shuffle();
        test_control_flow();
        test_mem_backpressure();
        test_halt();
        test_illegal(8'h07);
        test_illegal(8'hFD);
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+dv
design/forth_cfg_pkg.sv
design/forth_isa_pkg.sv
design/stack_if.sv
design/forth_program_rom.sv
design/forth_decode.sv
design/forth_stack.sv
design/forth_execute.sv
design/forth_cpu.sv
dv/tb_forth_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_forth_cpu
FILELIST  := src.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell grep -v '^+' $(FILELIST)) $(wildcard dv/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
